// File: verilog/adpcmb_params.svh
// ************************************************************
// Width, burst and step-size constants for the ADPCM-B voice
// Include at file scope before any module or package using them
// ************************************************************
`ifndef ADPCMB_PARAMS_SVH
`define ADPCMB_PARAMS_SVH

// Memory byte address width
`define ADPCMB_ADDR_W 24

// Decoder enables per nibble
`define ADPCMB_BURST_LEN 5

// Step size limits of the adaptive decoder
`define ADPCMB_STEP_MIN 127
`define ADPCMB_STEP_MAX 24576

// PCM word width
`define ADPCMB_PCM_W 16

`endif

// File: verilog/adpcmb_ctrl_pkg.sv
// ************************************************************
// Control-side types: channel configuration and memory fetch
// ************************************************************
`default_nettype none

`include "adpcmb_params.svh"

package adpcmb_ctrl_pkg;

    // Channel controls, all plain levels
    typedef struct packed {
        logic        on;        // Key-on
        logic        rep;       // Loop at end address
        logic        clr;       // Hold channel cleared
        logic [1:0]  lr;        // Pan, bit 1 left, bit 0 right
        logic [15:0] start;     // Start, 256-byte units
        logic [15:0] stop;      // End, 256-byte units
        logic [15:0] delta_n;   // Playback rate
        logic [7:0]  level;     // Envelope level
        logic [6:0]  pad;       // Unused
    } adpcmb_cfg_t;

    // Sample memory request
    typedef struct packed {
        logic [`ADPCMB_ADDR_W-1:0] addr;    // Byte address
        logic                      nib_sel; // 0 picks high nibble
        logic                      adv;     // Fetch strobe
    } mem_req_t;

endpackage

`default_nettype wire

// File: verilog/adpcmb_audio_pkg.sv
// ************************************************************
// Audio-side types and the ADPCM-B step adaptation table
// ************************************************************
`default_nettype none

`include "adpcmb_params.svh"

package adpcmb_audio_pkg;

    typedef logic signed [`ADPCMB_PCM_W-1:0] sample_t;   // Signed PCM word

    // Sign-magnitude ADPCM code
    typedef struct packed {
        logic       sign;   // 1 subtracts
        logic [2:0] mag;    // Magnitude
    } nibble_t;

    typedef struct packed {
        sample_t l;
        sample_t r;
    } stereo_t;

    // Step multiplier over 64, indexed by magnitude
    function automatic logic [7:0] step_mult(input logic [2:0] mag);
        case (mag)
            3'd4:    return 8'd77;
            3'd5:    return 8'd102;
            3'd6:    return 8'd128;
            3'd7:    return 8'd153;
            default: return 8'd57;  // Small codes shrink the step
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verilog/adpcmb_addr_cnt.sv
// ************************************************************
// Delta-N phase accumulator and nibble address counter
// Steps on cen55, strobes adv once per nibble to fetch
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "adpcmb_params.svh"

module adpcmb_addr_cnt (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen55,
    input  logic                      on,
    input  logic                      rep,
    input  logic                      clr,
    input  logic [15:0]               start,
    input  logic [15:0]               stop,
    input  logic [15:0]               delta_n,
    output adpcmb_ctrl_pkg::mem_req_t req
);
    localparam int NIB_W = `ADPCMB_ADDR_W + 1;    // Byte address plus nibble bit

    logic [15:0]      acc;          // Phase accumulator
    logic [16:0]      acc_nx;       // Carry on top
    logic [NIB_W-1:0] nib;          // Nibble counter
    logic [NIB_W-1:0] nib_start;
    logic [NIB_W-1:0] nib_last;
    logic             on_l;         // Key-on edge detect
    logic             running;
    logic             first;        // Start nibble not fetched yet
    logic             adv;

    assign acc_nx    = {1'b0, acc} + {1'b0, delta_n};
    assign nib_start = {start, 9'd0};       // start x 512 nibbles
    assign nib_last  = {stop, 9'h1ff};      // Low nibble of stop*256+255

    always_ff @(posedge clk) begin
        if (rst) begin
            acc     <= '0;
            nib     <= '0;
            on_l    <= 1'b0;
            running <= 1'b0;
            first   <= 1'b0;
            adv     <= 1'b0;
        end else begin
            on_l <= on;
            adv  <= 1'b0;                   // Single-cycle strobe
            if (clr || (on && !on_l)) begin
                acc     <= '0;              // Restart from start address
                nib     <= nib_start;
                running <= on;
                first   <= 1'b1;
            end else if (!on) begin
                running <= 1'b0;
            end else if (cen55 && running) begin
                acc <= acc_nx[15:0];
                if (acc_nx[16]) begin
                    if (first) begin
                        first <= 1'b0;      // Fetch the start nibble in place
                        adv   <= 1'b1;
                    end else if (nib == nib_last) begin
                        if (rep) begin
                            nib <= nib_start;   // Loop
                            adv <= 1'b1;
                        end else begin
                            running <= 1'b0;    // Wait for next key-on
                        end
                    end else begin
                        nib <= nib + 1'b1;
                        adv <= 1'b1;
                    end
                end
            end
        end
    end

    // Byte address is nibble count / 2
    assign req = '{addr: nib[NIB_W-1:1], nib_sel: nib[0], adv: adv};

endmodule

`default_nettype wire

// File: verilog/adpcmb_cen_burst.sv
// ************************************************************
// Passes exactly len clock enables after each start pulse
// Feeds the decoder sequencer one burst per nibble
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "adpcmb_params.svh"

module adpcmb_cen_burst #(
    parameter int len = `ADPCMB_BURST_LEN
) (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  logic start,
    output logic cen_out
);
    localparam int CNT_W = $clog2(len + 1);

    logic [CNT_W-1:0] cnt;      // Enables still to pass

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= CNT_W'(len);         // Restart even mid-burst
        end else if (cen && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // First pulse comes on the cen after start
    assign cen_out = cen & ~start & (cnt != '0);

endmodule

`default_nettype wire

// File: verilog/adpcmb_decoder.sv
// ************************************************************
// Adaptive ADPCM-B nibble decoder, one phase per burst enable
// Holds x and step between nibbles, publishes on last pulse
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "adpcmb_params.svh"

module adpcmb_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  logic                      on,
    input  adpcmb_audio_pkg::nibble_t code,
    output adpcmb_audio_pkg::sample_t pcm
);
    import adpcmb_audio_pkg::*;

    localparam int LAST  = `ADPCMB_BURST_LEN - 1;
    localparam int PH_W  = $clog2(`ADPCMB_BURST_LEN);

    logic [PH_W-1:0]    phase;      // Position within the burst
    nibble_t            nib;
    logic [15:0]        step;
    sample_t            x;          // Accumulated sample
    logic [15:0]        delta;
    logic [19:0]        delta_full; // (2m+1) x step
    logic signed [17:0] x_ext;
    logic signed [17:0] d_ext;
    logic signed [17:0] sum;
    sample_t            x_sat;
    logic [23:0]        step_full;  // step x mult
    logic [17:0]        step_nx;
    logic [15:0]        step_sat;

    assign delta_full = {nib.mag, 1'b1} * step;
    assign x_ext      = {{2{x[15]}}, x};
    assign d_ext      = {2'b00, delta};
    assign sum        = nib.sign ? x_ext - d_ext : x_ext + d_ext;

    always_comb begin
        if (sum > 18'sd32767)
            x_sat = 16'sh7fff;                 // Clip high
        else if (sum < -18'sd32768)
            x_sat = 16'sh8000;                 // Clip low
        else
            x_sat = sum[15:0];
    end

    assign step_full = step * step_mult(nib.mag);
    assign step_nx   = step_full[23:6];        // Divide by 64

    always_comb begin
        if (step_nx < 18'(`ADPCMB_STEP_MIN))
            step_sat = 16'(`ADPCMB_STEP_MIN);
        else if (step_nx > 18'(`ADPCMB_STEP_MAX))
            step_sat = 16'(`ADPCMB_STEP_MAX);
        else
            step_sat = step_nx[15:0];
    end

    always_ff @(posedge clk) begin
        if (rst || !on) begin
            phase <= '0;
            x     <= '0;
            step  <= 16'(`ADPCMB_STEP_MIN);
            pcm   <= '0;                    // Channel off reads as silence
        end else if (cen) begin
            phase <= (phase == PH_W'(LAST)) ? '0 : phase + 1'b1;
            case (phase)
                PH_W'(0): nib   <= code;              // Load
                PH_W'(1): delta <= delta_full[18:3];  // /8
                PH_W'(2): x     <= x_sat;             // Accumulate
                PH_W'(3): step  <= step_sat;          // Adapt
                default:  pcm   <= x;                 // Publish
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/adpcmb_gain_pan.sv
// ************************************************************
// Envelope level gain and stereo pan at the 55 kHz rate
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module adpcmb_gain_pan (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen55,
    input  logic [7:0]                level,
    input  logic [1:0]                lr,
    input  adpcmb_audio_pkg::sample_t pcm_in,
    output adpcmb_audio_pkg::stereo_t pcm
);
    import adpcmb_audio_pkg::*;

    logic signed [24:0] prod;       // sample x level
    sample_t            gained;
    logic               cen55_d;

    assign prod = pcm_in * $signed({1'b0, level});

    // Bits 23:8 equal prod >>> 8 since level < 256
    always_ff @(posedge clk) begin
        if (cen55)
            gained <= prod[23:8];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cen55_d <= 1'b0;
            pcm     <= '0;
        end else begin
            cen55_d <= cen55;
            if (cen55_d) begin
                pcm <= '{l: lr[1] ? gained : '0,    // Unselected side muted
                         r: lr[0] ? gained : '0};
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/adpcmb_drv.sv
// ************************************************************
// ADPCM-B voice top: address counter, fetch, decoder and gain
// Memory must answer two clk after the fetch strobe
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "adpcmb_params.svh"

module adpcmb_drv (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,        // Decoder-rate enable
    input  logic                        cen55,      // Output-rate pulse
    input  adpcmb_ctrl_pkg::adpcmb_cfg_t cfg,
    output logic [`ADPCMB_ADDR_W-1:0]   addr,
    input  logic [7:0]                  data,
    output logic                        roe_n,
    output adpcmb_audio_pkg::stereo_t   pcm
);
    import adpcmb_ctrl_pkg::*;
    import adpcmb_audio_pkg::*;

    mem_req_t   req;
    logic [1:0] adv_d;          // Fetch strobe delay line
    nibble_t    din;            // Captured nibble
    logic       cen_dec;
    logic       dec_on;
    sample_t    pcm_dec;

    assign addr   = req.addr;
    assign dec_on = cfg.on & ~cfg.clr;  // clr holds decoder at zero

    adpcmb_addr_cnt u_cnt (
        .clk     (clk),
        .rst     (rst),
        .cen55   (cen55),
        .on      (cfg.on),
        .rep     (cfg.rep),
        .clr     (cfg.clr),
        .start   (cfg.start),
        .stop    (cfg.stop),
        .delta_n (cfg.delta_n),
        .req     (req)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            roe_n <= 1'b1;
            adv_d <= '0;
        end else begin
            roe_n <= ~req.adv;                 // Read enable one clk after strobe
            adv_d <= {adv_d[0], req.adv};
        end
    end

    // High nibble first
    always_ff @(posedge clk) begin
        if (adv_d[1])
            din <= req.nib_sel ? data[3:0] : data[7:4];
    end

    adpcmb_cen_burst #(.len(`ADPCMB_BURST_LEN)) u_burst (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .start   (adv_d[1]),
        .cen_out (cen_dec)
    );

    adpcmb_decoder u_dec (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen_dec),
        .on   (dec_on),
        .code (din),
        .pcm  (pcm_dec)
    );

    adpcmb_gain_pan u_gain (
        .clk    (clk),
        .rst    (rst),
        .cen55  (cen55),
        .level  (cfg.level),
        .lr     (cfg.lr),
        .pcm_in (pcm_dec),
        .pcm    (pcm)
    );

endmodule

`default_nettype wire

// File: bench/adpcmb_tb.sv
// ************************************************************
// Directed testbench for the ADPCM-B voice top level
// Holds the sample memory model and a reference decoder
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "adpcmb_params.svh"

module adpcmb_tb;
    import adpcmb_ctrl_pkg::*;
    import adpcmb_audio_pkg::*;

    localparam int TAB_BASE = 'h1000;       // Random table at block 0x10
    localparam int TAB_SIZE = 512;          // Blocks 0x10 and 0x11

    logic                      clk;
    logic                      rst;
    logic                      cen;
    logic                      cen55;
    adpcmb_cfg_t               cfg;
    logic [`ADPCMB_ADDR_W-1:0] addr;
    logic [7:0]                data;
    logic                      roe_n;
    stereo_t                   pcm;

    logic [1:0] div3;                       // Decoder enable divider
    logic [5:0] div48;                      // Output rate divider
    logic [7:0] tab [TAB_SIZE];
    integer     seed;
    int         errors;
    int         tests_ok;
    int         tests_bad;

    adpcmb_drv uut (
        .clk(clk), .rst(rst), .cen(cen), .cen55(cen55), .cfg(cfg),
        .addr(addr), .data(data), .roe_n(roe_n), .pcm(pcm)
    );

    always #4 clk = ~clk;                   // 8 ns period

    always @(posedge clk) begin
        div3  <= (div3 == 2'd2) ? 2'd0 : div3 + 2'd1;
        div48 <= (div48 == 6'd47) ? 6'd0 : div48 + 6'd1;
        cen   <= (div3 == 2'd2);            // 1 in 3
        cen55 <= (div48 == 6'd47);          // 1 in 48
    end

    function automatic logic [7:0] mem_byte(input logic [`ADPCMB_ADDR_W-1:0] a);
        if (a >= TAB_BASE && a < TAB_BASE + TAB_SIZE)
            return tab[a - TAB_BASE];
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;    // Pattern outside the table
    endfunction

    // Byte valid one clk after the read enable
    always @(posedge clk) begin
        if (!roe_n)
            data <= mem_byte(addr);
    end

    // One nibble through the ADPCM-B rule
    task automatic ref_decode(input logic [3:0] code, inout int x, inout int step);
        int m;
        int mult;
        m = code[2:0];
        x = code[3] ? x - ((2 * m + 1) * step) / 8 : x + ((2 * m + 1) * step) / 8;
        if (x > 32767)
            x = 32767;
        else if (x < -32768)
            x = -32768;
        case (m)
            4:       mult = 77;
            5:       mult = 102;
            6:       mult = 128;
            7:       mult = 153;
            default: mult = 57;
        endcase
        step = (step * mult) / 64;
        if (step < `ADPCMB_STEP_MIN)
            step = `ADPCMB_STEP_MIN;
        else if (step > `ADPCMB_STEP_MAX)
            step = `ADPCMB_STEP_MAX;
    endtask

    function automatic sample_t gain(input int x, input int lv);
        return sample_t'((x * lv) >>> 8);
    endfunction

    function automatic logic [3:0] nib_at(input int k);
        return k[0] ? tab[k / 2][3:0] : tab[k / 2][7:4];   // High nibble first
    endfunction

    // Random magnitudes with the sign toward zero keep the stream off the clip limits
    task automatic fill_table();
        int x;
        int step;
        int m;
        int i;
        logic [3:0] c;
        x = 0;
        step = `ADPCMB_STEP_MIN;
        for (i = 0; i < 2 * TAB_SIZE; i++) begin
            m = $random(seed) & 7;
            if (step > 4096)
                m = m & 3;                  // Let a large step shrink
            c = {x > 0, m[2:0]};
            ref_decode(c, x, step);
            if (i % 2 == 0)
                tab[i / 2][7:4] = c;
            else
                tab[i / 2][3:0] = c;
        end
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %0d, got %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_pair(input string name, input stereo_t exp, input stereo_t act);
        if (act !== exp) begin
            $display("ERR %s: expected l=%0d r=%0d, got l=%0d r=%0d",
                     name, exp.l, exp.r, act.l, act.r);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [`ADPCMB_ADDR_W-1:0] exp,
                              input logic [`ADPCMB_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, got %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic wait_read(input string name, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < 200) begin
            @(negedge clk);
            ok = !roe_n;
            n++;
        end
        if (!ok) begin
            $display("%s: no memory read came within 200 cycles", name);
            errors++;
        end
    endtask

    task automatic wait_change(input string name, input stereo_t prev, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < 400) begin
            @(negedge clk);
            ok = (pcm !== prev);
            n++;
        end
        if (!ok) begin
            $display("%s: output never changed within 400 cycles", name);
            errors++;
        end
    endtask

    task automatic wait_silence(input string name, input int limit, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < limit) begin
            @(negedge clk);
            ok = (pcm === '0);
            n++;
        end
        if (!ok) begin
            $display("%s: output did not return to zero within %0d cycles", name, limit);
            errors++;
        end
    endtask

    // Off long enough for the outputs to settle at zero
    task automatic key_off();
        @(posedge clk);
        cfg.on  <= 1'b0;
        cfg.clr <= 1'b0;
        repeat (150) @(posedge clk);
    endtask

    task automatic key_on(input logic [15:0] s, input logic [15:0] e, input logic [15:0] dn,
                          input logic rep, input logic [7:0] lv, input logic [1:0] lrv);
        key_off();
        cfg <= '{on: 1'b1, rep: rep, clr: 1'b0, lr: lrv, start: s, stop: e,
                 delta_n: dn, level: lv, pad: 7'd0};
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errors - err0);
            tests_bad++;
        end
    endtask

    task automatic idle_after_reset();
        int e0;
        int n;
        e0 = errors;
        @(negedge clk);
        check_bit("reset", 1'b1, roe_n);
        check_pair("reset", '0, pcm);
        for (n = 0; n < 300; n++) begin
            @(negedge clk);
            if (roe_n !== 1'b1) begin
                $display("reset: a memory read came while the channel was off");
                errors++;
                break;
            end
        end
        report_test("reset", e0);
    endtask

    // One 256-byte block at 0x2000 and extra reads past its end
    task automatic address_sequence(input string name, input logic rep, input int extra);
        int e0;
        int k;
        bit ok;
        e0 = errors;
        ok = 1'b1;
        key_on(16'h0020, 16'h0020, 16'hffff, rep, 8'd255, 2'b11);
        for (k = 0; k < 512 + extra; k++) begin
            wait_read(name, ok);
            if (!ok)
                break;
            check_addr(name, 24'h002000 + (k % 512) / 2, addr);
        end
        for (k = 0; k < 480 && ok && !rep; k++) begin
            @(negedge clk);
            if (!roe_n) begin
                $display("%s: a memory read came after the end address", name);
                errors++;
                break;
            end
        end
        report_test(name, e0);
    endtask

    task automatic decode_stream(input string name, input logic [7:0] lv,
                                 input logic [1:0] lrv);
        int e0;
        int x;
        int step;
        int k;
        bit ok;
        sample_t g;
        stereo_t exp;
        e0 = errors;
        x = 0;
        step = `ADPCMB_STEP_MIN;
        key_on(16'h0010, 16'h0011, 16'h8000, 1'b0, lv, lrv);
        for (k = 0; k < 40; k++) begin
            ref_decode(nib_at(k), x, step);
            g = gain(x, lv);
            exp.l = lrv[1] ? g : '0;
            exp.r = lrv[0] ? g : '0;        // Unselected side stays silent
            wait_change(name, pcm, ok);
            if (!ok)
                break;
            check_pair(name, exp, pcm);
        end
        report_test(name, e0);
    endtask

    task automatic clear_restart();
        int e0;
        int x;
        int step;
        int k;
        bit ok;
        e0 = errors;
        x = 0;
        step = `ADPCMB_STEP_MIN;
        key_on(16'h0010, 16'h0011, 16'h8000, 1'b0, 8'd96, 2'b10);
        for (k = 0; k < 8; k++) begin
            wait_change("clear", pcm, ok);
            if (!ok)
                break;
        end
        @(posedge clk);
        cfg.clr <= 1'b1;
        wait_silence("clear", 96, ok);       // Two cen55 periods
        repeat (20) @(negedge clk);
        check_addr("clear", 24'h001000, addr);
        @(posedge clk);
        cfg.clr <= 1'b0;
        wait_read("clear", ok);
        if (ok)
            check_addr("clear", 24'h001000, addr);
        ref_decode(nib_at(0), x, step);     // Decoder restarts from zero
        wait_change("clear", pcm, ok);
        if (ok)
            check_sample("clear", gain(x, 96), pcm.l);
        report_test("clear", e0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b0;
        cen55 = 1'b0;
        cfg = '0;
        data = '0;
        div3 = '0;
        div48 = '0;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        seed = 32'h3b17_2649;
        fill_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        address_sequence("addr_seq", 1'b0, 0);
        address_sequence("repeat", 1'b1, 6);
        decode_stream("decode", 8'd255, 2'b11);
        decode_stream("level_pan", 8'd96, 2'b10);
        decode_stream("pan_right", 8'd160, 2'b01);
        clear_restart();
        $display("tests passed: %0d, failed: %0d", tests_ok, tests_bad);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/adpcmb_ctrl_pkg.sv
verilog/adpcmb_audio_pkg.sv
verilog/adpcmb_addr_cnt.sv
verilog/adpcmb_cen_burst.sv
verilog/adpcmb_decoder.sv
verilog/adpcmb_gain_pan.sv
verilog/adpcmb_drv.sv
bench/adpcmb_tb.sv
